/* include/crom_image.svh */
/*
 * Control ROM image, one microword per microaddress
 */
`ifndef CROM_IMAGE_SVH
`define CROM_IMAGE_SVH

// Field order: j, disp, ind_test, ir_load, xr_load, alu_fn, t_load
localparam crom_t crom_image [crom_depth] = '{
   // Fetch, latch IR, XR and DROM from d
   ua_fetch:    '{ua_disp,     1'b0, 1'b0, 1'b1, 1'b1, fn_hold, 1'b0},
   // Dispatch, extra cycle when I is set
   ua_disp:     '{ua_fetch,    1'b1, 1'b1, 1'b0, 1'b0, fn_hold, 1'b0},
   // Indirect word discarded here
   ua_indirect: '{ua_fetch,    1'b1, 1'b0, 1'b0, 1'b0, fn_hold, 1'b0},

   ////////////////////////////////////////
   // Execute routines, all return to fetch
   ////////////////////////////////////////
   ua_pass:     '{ua_fetch,    1'b0, 1'b0, 1'b0, 1'b0, fn_pass, 1'b1},
   ua_add:      '{ua_fetch,    1'b0, 1'b0, 1'b0, 1'b0, fn_add,  1'b1},
   ua_sub:      '{ua_fetch,    1'b0, 1'b0, 1'b0, 1'b0, fn_sub,  1'b1},
   ua_zero:     '{ua_fetch,    1'b0, 1'b0, 1'b0, 1'b0, fn_zero, 1'b1},
   ua_and:      '{ua_fetch,    1'b0, 1'b0, 1'b0, 1'b0, fn_and,  1'b1},
   ua_xor:      '{ua_fetch,    1'b0, 1'b0, 1'b0, 1'b0, fn_xor,  1'b1},
   ua_or:       '{ua_fetch,    1'b0, 1'b0, 1'b0, 1'b0, fn_or,   1'b1},
   // No-op, t not written
   ua_hold:     '{ua_fetch,    1'b0, 1'b0, 1'b0, 1'b0, fn_hold, 1'b0},

   // Unused locations fall back to fetch
   default:     '{ua_fetch,    1'b0, 1'b0, 1'b0, 1'b0, fn_hold, 1'b0}
};

`endif

/* hw/ks10_pkg.sv */
/*
 * Shared widths, opcode, ALU-function and microaddress enums,
 * and the microword and dispatch-entry structs
 */
`default_nettype none

package ks10_pkg;

   // Machine word with bit 0 as the MSB
   localparam int word_width = 36;

   // Control store size and microaddress width
   localparam int crom_depth  = 16;
   localparam int uaddr_width = $clog2(crom_depth);

   ////////////////////////////////////////
   // Instruction opcodes (octal)
   ////////////////////////////////////////

   // Anything not listed runs as a no-op
   typedef enum logic [8:0] {
      op_move = 9'o200,
      op_add  = 9'o270,
      op_sub  = 9'o274,
      op_setz = 9'o400,
      op_and  = 9'o404,
      op_xor  = 9'o430,
      op_ior  = 9'o434
   } opcode_e;

   // ALU function select
   typedef enum logic [2:0] {
      fn_pass,
      fn_add,
      fn_sub,
      fn_zero,
      fn_and,
      fn_xor,
      fn_or,
      fn_hold
   } alu_fn_e;

   ////////////////////////////////////////
   // Fixed microaddresses
   ////////////////////////////////////////

   typedef enum logic [uaddr_width-1:0] {
      ua_fetch    = 4'd0,
      ua_disp     = 4'd1,
      ua_indirect = 4'd2,
      // One execute routine per ALU function
      ua_pass     = 4'd3,
      ua_add      = 4'd4,
      ua_sub      = 4'd5,
      ua_zero     = 4'd6,
      ua_and      = 4'd7,
      ua_xor      = 4'd8,
      ua_or       = 4'd9,
      ua_hold     = 4'd10
   } uaddr_e;

   // 12-bit microword
   typedef struct packed {
      uaddr_e  j;          // Next address
      logic    disp;       // Take next address from DROM
      logic    ind_test;   // Divert to indirect cycle when I set
      logic    ir_load;    // Fetch strobe
      logic    xr_load;
      alu_fn_e alu_fn;
      logic    t_load;
   } crom_t;

   // 7-bit dispatch entry
   typedef struct packed {
      uaddr_e  addr;
      alu_fn_e alu_fn;
   } drom_t;

endpackage

`default_nettype wire

/* hw/microcontroller.sv */
/*
 * Microsequencer with control ROM, next-address and dispatch
 * logic, and AC-zero store suppression
 */
`timescale 1ns/1ps
`default_nettype none

module microcontroller (
   input  wire              clk,
   input  wire              rst_n,
   input  wire              ac_zero,
   input  wire              indirect,
   input  wire ks10_pkg::drom_t drom,
   output ks10_pkg::crom_t  crom,
   output logic             t_store
);

   import ks10_pkg::*;

   `include "crom_image.svh"

   // Microaddress register
   uaddr_e upc;
   uaddr_e next_addr;

   ////////////////////////////////////////
   // Control store read
   ////////////////////////////////////////

   // Asynchronous read, microword valid for the whole cycle
   assign crom = crom_image[upc];

   // Next address select
   always_comb begin
      next_addr = crom.j;
      if (crom.disp) begin
         // Indirect bit diverts the dispatch one cycle
         if (crom.ind_test && indirect)
            next_addr = ua_indirect;
         else
            next_addr = drom.addr;
      end
   end

   // Reset lands on fetch
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         upc <= ua_fetch;
      else
         upc <= next_addr;
   end

   // AC of zero means no write to t
   assign t_store = crom.t_load & ~ac_zero;

endmodule

`default_nettype wire

/* hw/drom.sv */
/*
 * Registered dispatch ROM, opcode to routine address and ALU function
 */
`timescale 1ns/1ps
`default_nettype none

module drom (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    load,
   input  wire ks10_pkg::opcode_e opcode,
   output ks10_pkg::drom_t        entry
);

   import ks10_pkg::*;

   drom_t lookup;

   ////////////////////////////////////////
   // Opcode decode
   ////////////////////////////////////////

   always_comb begin
      case (opcode)
         op_move: lookup = '{ua_pass, fn_pass};
         op_add:  lookup = '{ua_add,  fn_add};
         op_sub:  lookup = '{ua_sub,  fn_sub};
         op_setz: lookup = '{ua_zero, fn_zero};
         op_and:  lookup = '{ua_and,  fn_and};
         op_xor:  lookup = '{ua_xor,  fn_xor};
         op_ior:  lookup = '{ua_or,   fn_or};
         // Unknown opcodes are no-ops
         default: lookup = '{ua_hold, fn_hold};
      endcase
   end

   // Loaded with the IR so the entry is ready in the DISP cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         entry <= '0;
      else if (load)
         entry <= lookup;
   end

endmodule

`default_nettype wire

/* hw/ir.sv */
/*
 * Instruction register, opcode and AC fields with AC-zero flag
 */
`timescale 1ns/1ps
`default_nettype none

module ir (
   input  wire                                  clk,
   input  wire                                  rst_n,
   input  wire                                  load,
   input  wire [0:ks10_pkg::word_width-1]       d,
   output ks10_pkg::opcode_e                    opcode,
   output logic                                 ac_zero
);

   import ks10_pkg::*;

   // Opcode field, bits 0 to 8
   logic [0:8] op_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         op_q    <= '0;
         ac_zero <= 1'b1;   // Cleared AC field reads as zero
      end else if (load) begin
         op_q    <= d[0:8];
         ac_zero <= (d[9:12] == 4'b0000);
      end
   end

   // Bypass in the fetch cycle so the DROM captures the new opcode
   assign opcode = opcode_e'(load ? d[0:8] : op_q);

endmodule

`default_nettype wire

/* hw/xr.sv */
/*
 * Index register, index field and indirect bit
 */
`timescale 1ns/1ps
`default_nettype none

module xr (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            load,
   input  wire [0:ks10_pkg::word_width-1] d,
   output logic [0:3]                     x,
   output logic                           indirect
);

   ////////////////////////////////////////
   // Instruction word fields
   ////////////////////////////////////////

   // I is bit 13, X is bits 14 to 17
   logic       i_bit;
   logic [0:3] x_field;

   assign i_bit   = d[13];
   assign x_field = d[14:17];

   // Held for the rest of the instruction
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         x        <= '0;
         indirect <= 1'b0;
      end else if (load) begin
         x        <= x_field;
         indirect <= i_bit;
      end
   end

endmodule

`default_nettype wire

/* hw/alu.sv */
/*
 * 36-bit ALU, operand indexing and result register t
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire ks10_pkg::alu_fn_e         fn,
   input  wire [0:3]                      x,
   input  wire [0:ks10_pkg::word_width-1] d,
   input  wire                            t_store,
   output logic [0:ks10_pkg::word_width-1] t
);

   import ks10_pkg::*;

   logic [0:word_width-1] operand;
   logic [0:word_width-1] result;

   ////////////////////////////////////////
   // Operand indexing
   ////////////////////////////////////////

   // Nonzero X offsets the operand, wraps mod 2**36
   assign operand = d + {{(word_width-4){1'b0}}, x};

   // Function select
   always_comb begin
      case (fn)
         fn_pass: result = operand;
         fn_add:  result = t + operand;
         fn_sub:  result = t - operand;
         fn_zero: result = '0;
         fn_and:  result = t & operand;
         fn_xor:  result = t ^ operand;
         fn_or:   result = t | operand;
         default: result = t;   // fn_hold
      endcase
   end

   // Result register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         t <= '0;
      else if (t_store)
         t <= result;
   end

endmodule

`default_nettype wire

/* hw/ks10.sv */
/*
 * Processor slice top, sequencer, IR, XR, DROM and ALU
 */
`timescale 1ns/1ps
`default_nettype none

module ks10 (
   input  wire                             clk,
   input  wire                             rst_n,
   input  wire [0:ks10_pkg::word_width-1]  d,
   output logic [0:ks10_pkg::word_width-1] t,
   output ks10_pkg::crom_t                 crom
);

   import ks10_pkg::*;

   logic       ac_zero;
   logic       indirect;
   logic       t_store;
   logic [0:3] x;
   opcode_e    opcode;
   drom_t      drom_entry;

   ////////////////////////////////////////
   // Sequencer
   ////////////////////////////////////////

   microcontroller u_mc (
      .clk      (clk),
      .rst_n    (rst_n),
      .ac_zero  (ac_zero),
      .indirect (indirect),
      .drom     (drom_entry),
      .crom     (crom),
      .t_store  (t_store)
   );

   // IR, XR and DROM all load on the fetch strobe
   ir u_ir (
      .clk     (clk),
      .rst_n   (rst_n),
      .load    (crom.ir_load),
      .d       (d),
      .opcode  (opcode),
      .ac_zero (ac_zero)
   );

   xr u_xr (
      .clk      (clk),
      .rst_n    (rst_n),
      .load     (crom.ir_load),
      .d        (d),
      .x        (x),
      .indirect (indirect)
   );

   drom u_drom (
      .clk    (clk),
      .rst_n  (rst_n),
      .load   (crom.ir_load),
      .opcode (opcode),
      .entry  (drom_entry)
   );

   // ALU function comes from the dispatch entry
   alu u_alu (
      .clk     (clk),
      .rst_n   (rst_n),
      .fn      (drom_entry.alu_fn),
      .x       (x),
      .d       (d),
      .t_store (t_store),
      .t       (t)
   );

endmodule

`default_nettype wire

/* verification/ks10_chk.sv */
/*
 * Bound checker with concurrent checks on microsequencing and t
 */
`timescale 1ns/1ps
`default_nettype none

module ks10_chk (
   input wire                            clk,
   input wire                            rst_n,
   input wire ks10_pkg::crom_t           crom,
   input wire [0:ks10_pkg::word_width-1] t,
   input wire                            t_store,
   input wire                            indirect
);

   // Cycles since the last fetch strobe
   logic [2:0] since_fetch;
   logic       at_disp;
   logic       at_indirect;

   // DISP is the only word that tests I
   // INDIRECT is the only other dispatching word
   assign at_disp     = crom.disp & crom.ind_test;
   assign at_indirect = crom.disp & ~crom.ind_test;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         since_fetch <= '0;
      else if (crom.ir_load)
         since_fetch <= '0;
      else
         since_fetch <= since_fetch + 3'd1;
   end

   ////////////////////////////////////////
   // Properties
   ////////////////////////////////////////

   fetch_recurs: assert property (@(posedge clk) disable iff (!rst_n)
      since_fetch < 3'd4)
      else $error("ir_load absent for 4 cycles");

   t_stable: assert property (@(posedge clk) disable iff (!rst_n)
      !t_store |=> $stable(t))
      else $error("t changed without t_store");

   indirect_path: assert property (@(posedge clk) disable iff (!rst_n)
      at_disp |=> (at_indirect == $past(indirect)))
      else $error("indirect cycle taken against the I bit");

endmodule

bind ks10 ks10_chk u_chk (
   .clk      (clk),
   .rst_n    (rst_n),
   .crom     (crom),
   .t        (t),
   .t_store  (t_store),
   .indirect (indirect)
);

`default_nettype wire

/* verification/ks10_tb.sv */
/*
 * Testbench for the processor slice, instruction table applied in a loop,
 * fetch timing and t checks, watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module ks10_tb;

   import ks10_pkg::*;

   localparam int num_vectors   = 16;
   localparam int reset_cycles  = 10;
   localparam int margin_cycles = 20;

   // One table row, instruction plus the words that follow it
   typedef struct packed {
      logic [0:word_width-1] instr;
      logic [0:word_width-1] operand;
      logic [0:word_width-1] dummy;
      logic [0:word_width-1] t_exp;
   } vector_t;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic [0:word_width-1] d;
   logic [0:word_width-1] t;
   crom_t                 crom;

   vector_t vectors [num_vectors];
   int      fill_idx   = 0;
   int      cycle_cnt  = 0;
   int      last_fetch = 0;

   ks10 dut (
      .clk   (clk),
      .rst_n (rst_n),
      .d     (d),
      .t     (t),
      .crom  (crom)
   );

   // 20 ns clock
   always #10 clk = ~clk;

   // Free cycle count, read at the falling edge
   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   ////////////////////////////////////////
   // Table helpers
   ////////////////////////////////////////

   // Opcode 0-8, AC 9-12, I 13, X 14-17, Y 18-35
   function automatic logic [0:word_width-1] encode_instr(input logic [8:0] op,
         input logic [3:0] ac, input logic ind, input logic [3:0] xf, input logic [17:0] y);
      return {op, ac, ind, xf, y};
   endfunction

   task automatic add_vector(input logic [8:0] op, input logic [3:0] ac, input logic ind,
                             input logic [3:0] xf, input logic [0:word_width-1] operand,
                             input logic [0:word_width-1] dummy,
                             input logic [0:word_width-1] t_exp);
      vectors[fill_idx] = '{encode_instr(op, ac, ind, xf, 18'(fill_idx)), operand, dummy, t_exp};
      fill_idx++;
   endtask

   // Expected t follows the ALU rules, running value carried row to row
   task automatic build_table();
      add_vector(op_move, 4'd1, 1'b0, 4'd0, 36'h012345678, 36'h5a5a5a5a5, 36'h012345678);
      // Wraps past 2**36
      add_vector(op_add,  4'd1, 1'b0, 4'd0, 36'hfffffffff, 36'h5a5a5a5a5, 36'h012345677);
      // Borrows below zero
      add_vector(op_sub,  4'd1, 1'b0, 4'd0, 36'h012345678, 36'h5a5a5a5a5, 36'hfffffffff);
      add_vector(op_and,  4'd2, 1'b0, 4'd0, 36'h0f0f0f0f0, 36'h5a5a5a5a5, 36'h0f0f0f0f0);
      add_vector(op_xor,  4'd3, 1'b0, 4'd0, 36'hffff00000, 36'h5a5a5a5a5, 36'hf0f00f0f0);
      add_vector(op_ior,  4'd1, 1'b0, 4'd0, 36'h00000000f, 36'h5a5a5a5a5, 36'hf0f00f0ff);
      add_vector(op_setz, 4'd1, 1'b0, 4'd0, 36'h123456789, 36'h5a5a5a5a5, 36'h000000000);
      // Indexed, 10 plus X of 5
      add_vector(op_move, 4'd1, 1'b0, 4'd5, 36'h00000000a, 36'h5a5a5a5a5, 36'h00000000f);
      add_vector(op_add,  4'd1, 1'b0, 4'd7, 36'hffffffff0, 36'h5a5a5a5a5, 36'h000000006);
      // Indirect, dummy word must be dropped
      add_vector(op_move, 4'd1, 1'b1, 4'd0, 36'h0abcdef01, 36'h555555555, 36'h0abcdef01);
      add_vector(op_add,  4'd1, 1'b1, 4'd1, 36'h0000000ff, 36'hfffffffff, 36'h0abcdf001);
      // AC of zero, t untouched
      add_vector(op_move, 4'd0, 1'b0, 4'd0, 36'h111111111, 36'h5a5a5a5a5, 36'h0abcdf001);
      add_vector(op_setz, 4'd0, 1'b0, 4'd0, 36'h123456789, 36'h5a5a5a5a5, 36'h0abcdf001);
      // Unknown opcodes run as no-ops
      add_vector(9'o777,  4'd5, 1'b0, 4'd0, 36'h222222222, 36'h5a5a5a5a5, 36'h0abcdf001);
      add_vector(9'o000,  4'd1, 1'b1, 4'd0, 36'h333333333, 36'h444444444, 36'h0abcdf001);
      add_vector(op_sub,  4'd4, 1'b0, 4'd0, 36'h000000001, 36'h5a5a5a5a5, 36'h0abcdf000);
   endtask

   ////////////////////////////////////////
   // Fetch wait and checks
   ////////////////////////////////////////

   // Sample at the falling edge, give up after limit extra cycles
   task automatic wait_fetch(input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while (!crom.ir_load && n < limit) begin
         n++;
         @(negedge clk);
      end
      assert (crom.ir_load) else begin
         $display("Fetch strobe ir_load missing for %0d cycles", limit + 1);
         $display("SIMULATION FAILED");
         $fatal(1, "stopping at first error");
      end
   endtask

   // Gap of 0 means no previous fetch to measure from
   task automatic check_fetch(input int limit, input int gap_exp,
                              input logic [0:word_width-1] t_exp);
      int gap;
      wait_fetch(limit);
      gap = cycle_cnt - last_fetch;
      last_fetch = cycle_cnt;
      if (gap_exp != 0) begin
         assert (gap == gap_exp) else begin
            $display("Mismatch fetch_gap: expected %h got %h", gap_exp, gap);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first error");
         end
      end
      // Result of the previous instruction shows in this fetch
      assert (t == t_exp) else begin
         $display("Mismatch t: expected %h got %h", t_exp, t);
         $display("SIMULATION FAILED");
         $fatal(1, "stopping at first error");
      end
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial begin : stimulus
      vector_t               vec;
      logic [0:word_width-1] prev_t;
      int                    prev_len;
      rst_n = 1'b0;
      d     = '0;
      build_table();
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
      d     <= vectors[0].instr;
      prev_t   = '0;
      prev_len = 0;
      for (int i = 0; i < num_vectors; i++) begin
         // First fetch must be right out of reset
         check_fetch((i == 0) ? 0 : 4, prev_len, prev_t);
         vec = vectors[i];
         // DISP cycle, d unused
         @(posedge clk);
         d <= vec.dummy;
         // Extra cycle with the discarded word
         if (vec.instr[13]) begin
            @(posedge clk);
            d <= vec.dummy;
         end
         @(posedge clk);
         d <= vec.operand;
         @(posedge clk);
         d <= (i + 1 < num_vectors) ? vectors[i + 1].instr : '0;
         prev_t   = vec.t_exp;
         prev_len = vec.instr[13] ? 4 : 3;
      end
      // Last result lands in the trailing fetch
      check_fetch(4, prev_len, prev_t);
      $display("SIMULATION PASSED");
      $finish;
   end

   // Worst case is 4 cycles per row plus one trailing fetch
   initial begin : watchdog
      repeat (reset_cycles + (num_vectors + 1) * 4 + margin_cycles) @(posedge clk);
      $display("Timeout: the instruction table did not finish in time");
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

/* ks10.f */
+incdir+include
hw/ks10_pkg.sv
hw/microcontroller.sv
hw/drom.sv
hw/ir.sv
hw/xr.sv
hw/alu.sv
hw/ks10.sv
verification/ks10_chk.sv
verification/ks10_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the ks10 testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ks10_tb -f ks10.f \
   --Mdir obj_dir -o ks10_sim > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/ks10_sim > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log

grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
